/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_boot -f verilog.f -o tb_boot > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_boot > sim.log 2>&1

grep -q "^PASS: all tests$" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* src/boot_cfg.svh */
`ifndef BOOT_CFG_SVH
`define BOOT_CFG_SVH

// I/O command bus
`define BOOT_ADDR_W        12
`define BOOT_DATA_W        32

// Word RAM below configuration space
`define BOOT_RAM_WORDS     256
`define BOOT_RAM_AW        8

// Address bit 11 selects configuration space
`define BOOT_CFG_BIT       11
`define BOOT_FREEZE_ADDR   12'h800
`define BOOT_TABLE_BASE    12'h810

// Configuration table
`define BOOT_TABLE_WORDS   16
`define BOOT_TABLE_AW      4

// Entry i holds i ^ key
`define BOOT_TABLE_KEY     32'h5A3C_96E1

`endif

/* src/boot_pkg.sv */
`default_nettype none

package boot_pkg;

   // Loader sequencing, shared by both boot agents
   typedef enum logic [1:0]
   {
      ld_idle = 2'd0,
      ld_cmd  = 2'd1,
      ld_resp = 2'd2,
      ld_done = 2'd3
   } loader_state_e;

   // NBF record opcodes
   typedef enum logic
   {
      nbf_op_write  = 1'b0,
      nbf_op_finish = 1'b1
   } nbf_op_e;

endpackage

`default_nettype wire

/* src/boot_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module boot_top
   (
      input  wire                      clk_i,
      input  wire                      rst_i,
      input  wire                      nbf_v_i,
      input  wire boot_pkg::nbf_op_e   nbf_op_i,
      input  wire [`BOOT_ADDR_W-1:0]   nbf_addr_i,
      input  wire [`BOOT_DATA_W-1:0]   nbf_data_i,
      output logic                     nbf_ready_o,
      input  wire [`BOOT_ADDR_W-1:0]   host_rd_addr_i,
      output logic [`BOOT_DATA_W-1:0]  host_rd_data_o,
      output logic                     freeze_o,
      output logic                     done_o
   );

   logic                         cfg_done;

   logic                         cfg_cmd_v;
   logic [`BOOT_ADDR_W-1:0]      cfg_cmd_addr;
   logic [`BOOT_DATA_W-1:0]      cfg_cmd_data;
   logic                         cfg_cmd_yumi;
   logic                         cfg_resp_v;
   logic                         cfg_resp_ready;

   logic                         nbf_cmd_v;
   logic [`BOOT_ADDR_W-1:0]      nbf_cmd_addr;
   logic [`BOOT_DATA_W-1:0]      nbf_cmd_data;
   logic                         nbf_cmd_yumi;
   logic                         nbf_resp_v;
   logic                         nbf_resp_ready;

   logic                         io_cmd_v;
   logic [`BOOT_ADDR_W-1:0]      io_cmd_addr;
   logic [`BOOT_DATA_W-1:0]      io_cmd_data;
   logic                         io_cmd_yumi;
   logic                         io_resp_v;
   logic                         io_resp_ready;

   cfg_loader i_cfg_loader
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.io_cmd_v_o(cfg_cmd_v)
      ,.io_cmd_addr_o(cfg_cmd_addr)
      ,.io_cmd_data_o(cfg_cmd_data)
      ,.io_cmd_yumi_i(cfg_cmd_yumi)
      ,.io_resp_v_i(cfg_resp_v)
      ,.io_resp_ready_o(cfg_resp_ready)
      ,.done_o(cfg_done)
      );

   nbf_loader i_nbf_loader
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cfg_done_i(cfg_done)
      ,.nbf_v_i(nbf_v_i)
      ,.nbf_op_i(nbf_op_i)
      ,.nbf_addr_i(nbf_addr_i)
      ,.nbf_data_i(nbf_data_i)
      ,.nbf_ready_o(nbf_ready_o)
      ,.io_cmd_v_o(nbf_cmd_v)
      ,.io_cmd_addr_o(nbf_cmd_addr)
      ,.io_cmd_data_o(nbf_cmd_data)
      ,.io_cmd_yumi_i(nbf_cmd_yumi)
      ,.io_resp_v_i(nbf_resp_v)
      ,.io_resp_ready_o(nbf_resp_ready)
      ,.done_o(done_o)
      );

   load_arbiter i_load_arbiter
      (.cfg_done_i(cfg_done)
      ,.cfg_cmd_v_i(cfg_cmd_v)
      ,.cfg_cmd_addr_i(cfg_cmd_addr)
      ,.cfg_cmd_data_i(cfg_cmd_data)
      ,.cfg_cmd_yumi_o(cfg_cmd_yumi)
      ,.cfg_resp_v_o(cfg_resp_v)
      ,.cfg_resp_ready_i(cfg_resp_ready)
      ,.nbf_cmd_v_i(nbf_cmd_v)
      ,.nbf_cmd_addr_i(nbf_cmd_addr)
      ,.nbf_cmd_data_i(nbf_cmd_data)
      ,.nbf_cmd_yumi_o(nbf_cmd_yumi)
      ,.nbf_resp_v_o(nbf_resp_v)
      ,.nbf_resp_ready_i(nbf_resp_ready)
      ,.io_cmd_v_o(io_cmd_v)
      ,.io_cmd_addr_o(io_cmd_addr)
      ,.io_cmd_data_o(io_cmd_data)
      ,.io_cmd_yumi_i(io_cmd_yumi)
      ,.io_resp_v_i(io_resp_v)
      ,.io_resp_ready_o(io_resp_ready)
      );

   io_target i_io_target
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.io_cmd_v_i(io_cmd_v)
      ,.io_cmd_addr_i(io_cmd_addr)
      ,.io_cmd_data_i(io_cmd_data)
      ,.io_cmd_yumi_o(io_cmd_yumi)
      ,.io_resp_v_o(io_resp_v)
      ,.io_resp_ready_i(io_resp_ready)
      ,.freeze_o(freeze_o)
      ,.host_rd_addr_i(host_rd_addr_i)
      ,.host_rd_data_o(host_rd_data_o)
      );

endmodule

`default_nettype wire

/* src/cfg_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module cfg_loader
   (
      input  wire                      clk_i,
      input  wire                      rst_i,
      output logic                     io_cmd_v_o,
      output logic [`BOOT_ADDR_W-1:0]  io_cmd_addr_o,
      output logic [`BOOT_DATA_W-1:0]  io_cmd_data_o,
      input  wire                      io_cmd_yumi_i,
      input  wire                      io_resp_v_i,
      output logic                     io_resp_ready_o,
      output logic                     done_o
   );

   // Write 0 sets freeze, writes 1 to 16 fill the table
   localparam int unsigned last_wr_lp = `BOOT_TABLE_WORDS;

   boot_pkg::loader_state_e      state_q;
   logic [`BOOT_TABLE_AW:0]      wr_cnt_q;
   logic [`BOOT_TABLE_AW:0]      entry_idx;

   always_comb
   begin
      entry_idx = wr_cnt_q - 1'b1;
      if (wr_cnt_q == '0)
      begin
         io_cmd_addr_o = `BOOT_FREEZE_ADDR;
         io_cmd_data_o = `BOOT_DATA_W'(1);
      end
      else
      begin
         io_cmd_addr_o = `BOOT_TABLE_BASE + `BOOT_ADDR_W'(entry_idx[`BOOT_TABLE_AW-1:0]);
         io_cmd_data_o = `BOOT_DATA_W'(entry_idx[`BOOT_TABLE_AW-1:0]) ^ `BOOT_TABLE_KEY;
      end
   end

   // Starts straight in ld_cmd so the first write goes out as reset drops
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q  <= boot_pkg::ld_cmd;
         wr_cnt_q <= '0;
      end
      else
      begin
         case (state_q)
            boot_pkg::ld_cmd:
               if (io_cmd_yumi_i)
                  state_q <= boot_pkg::ld_resp;
            boot_pkg::ld_resp:
               if (io_resp_v_i)
               begin
                  if (wr_cnt_q == last_wr_lp)
                     state_q <= boot_pkg::ld_done;
                  else
                  begin
                     wr_cnt_q <= wr_cnt_q + 1'b1;
                     state_q  <= boot_pkg::ld_cmd;
                  end
               end
            boot_pkg::ld_done:
               state_q <= boot_pkg::ld_done;
            default:
               state_q <= boot_pkg::ld_cmd;
         endcase
      end
   end

   assign io_cmd_v_o      = (state_q == boot_pkg::ld_cmd);
   assign io_resp_ready_o = (state_q == boot_pkg::ld_resp);
   assign done_o          = (state_q == boot_pkg::ld_done);

   // A new command only follows a retired response
   a_cmd_after_resp: assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(io_cmd_v_o) |-> $past(io_resp_v_i && io_resp_ready_o))
      else $error("cfg_loader: command raised while a response is awaited");

endmodule

`default_nettype wire

/* src/io_target.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module io_target
   (
      input  wire                      clk_i,
      input  wire                      rst_i,
      input  wire                      io_cmd_v_i,
      input  wire [`BOOT_ADDR_W-1:0]   io_cmd_addr_i,
      input  wire [`BOOT_DATA_W-1:0]   io_cmd_data_i,
      output logic                     io_cmd_yumi_o,
      output logic                     io_resp_v_o,
      input  wire                      io_resp_ready_i,
      output logic                     freeze_o,
      input  wire [`BOOT_ADDR_W-1:0]   host_rd_addr_i,
      output logic [`BOOT_DATA_W-1:0]  host_rd_data_o
   );

   logic                         resp_q;
   logic                         freeze_q;
   logic [`BOOT_DATA_W-1:0]      table_mem [`BOOT_TABLE_WORDS];
   logic [`BOOT_DATA_W-1:0]      ram_mem [`BOOT_RAM_WORDS];
   logic                         wr_cfg;
   logic                         wr_freeze;
   logic                         wr_table;
   logic                         wr_ram;
   logic [`BOOT_ADDR_W-1:0]      wr_tbl_off;
   logic [`BOOT_ADDR_W-1:0]      rd_tbl_off;

   // One response slot, so nothing is taken while it is full
   assign io_cmd_yumi_o = io_cmd_v_i && !resp_q;

   // Offsets below the table base wrap high and miss the range check
   assign wr_cfg     = io_cmd_addr_i[`BOOT_CFG_BIT];
   assign wr_tbl_off = io_cmd_addr_i - `BOOT_TABLE_BASE;
   assign rd_tbl_off = host_rd_addr_i - `BOOT_TABLE_BASE;
   assign wr_freeze  = io_cmd_yumi_o && (io_cmd_addr_i == `BOOT_FREEZE_ADDR);
   assign wr_table   = io_cmd_yumi_o && wr_cfg && (wr_tbl_off < `BOOT_TABLE_WORDS);
   assign wr_ram     = io_cmd_yumi_o && !wr_cfg;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         resp_q   <= 1'b0;
         freeze_q <= 1'b0;
      end
      else
      begin
         resp_q <= io_cmd_yumi_o || (resp_q && !io_resp_ready_i);
         if (wr_freeze)
            freeze_q <= io_cmd_data_i[0];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_table)
         table_mem[wr_tbl_off[`BOOT_TABLE_AW-1:0]] <= io_cmd_data_i;
      if (wr_ram)
         ram_mem[io_cmd_addr_i[`BOOT_RAM_AW-1:0]] <= io_cmd_data_i;
   end

   // Host port uses the bus address map
   always_ff @(posedge clk_i)
   begin
      if (!host_rd_addr_i[`BOOT_CFG_BIT])
         host_rd_data_o <= ram_mem[host_rd_addr_i[`BOOT_RAM_AW-1:0]];
      else if (host_rd_addr_i == `BOOT_FREEZE_ADDR)
         host_rd_data_o <= `BOOT_DATA_W'(freeze_q);
      else if (rd_tbl_off < `BOOT_TABLE_WORDS)
         host_rd_data_o <= table_mem[rd_tbl_off[`BOOT_TABLE_AW-1:0]];
      else
         host_rd_data_o <= '0;
   end

   assign io_resp_v_o = resp_q;
   assign freeze_o    = freeze_q;

   // Response holds until the loader takes it
   a_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (io_resp_v_o && !io_resp_ready_i) |=> io_resp_v_o)
      else $error("io_target: response dropped before it was retired");

endmodule

`default_nettype wire

/* src/load_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module load_arbiter
   (
      input  wire                      cfg_done_i,
      input  wire                      cfg_cmd_v_i,
      input  wire [`BOOT_ADDR_W-1:0]   cfg_cmd_addr_i,
      input  wire [`BOOT_DATA_W-1:0]   cfg_cmd_data_i,
      output logic                     cfg_cmd_yumi_o,
      output logic                     cfg_resp_v_o,
      input  wire                      cfg_resp_ready_i,
      input  wire                      nbf_cmd_v_i,
      input  wire [`BOOT_ADDR_W-1:0]   nbf_cmd_addr_i,
      input  wire [`BOOT_DATA_W-1:0]   nbf_cmd_data_i,
      output logic                     nbf_cmd_yumi_o,
      output logic                     nbf_resp_v_o,
      input  wire                      nbf_resp_ready_i,
      output logic                     io_cmd_v_o,
      output logic [`BOOT_ADDR_W-1:0]  io_cmd_addr_o,
      output logic [`BOOT_DATA_W-1:0]  io_cmd_data_o,
      input  wire                      io_cmd_yumi_i,
      input  wire                      io_resp_v_i,
      output logic                     io_resp_ready_o
   );

   // Loaders run one after the other, so cfg_done alone picks the owner
   always_comb
   begin
      io_cmd_v_o      = cfg_done_i ? nbf_cmd_v_i      : cfg_cmd_v_i;
      io_cmd_addr_o   = cfg_done_i ? nbf_cmd_addr_i   : cfg_cmd_addr_i;
      io_cmd_data_o   = cfg_done_i ? nbf_cmd_data_i   : cfg_cmd_data_i;
      io_resp_ready_o = cfg_done_i ? nbf_resp_ready_i : cfg_resp_ready_i;

      cfg_cmd_yumi_o  = !cfg_done_i && io_cmd_yumi_i;
      cfg_resp_v_o    = !cfg_done_i && io_resp_v_i;
      nbf_cmd_yumi_o  = cfg_done_i && io_cmd_yumi_i;
      nbf_resp_v_o    = cfg_done_i && io_resp_v_i;
   end

   // The config loader must be silent once it reports done
   always_comb
   begin
      if (cfg_done_i)
         a_cfg_quiet: assert (!cfg_cmd_v_i)
            else $error("load_arbiter: config command after cfg_done");
   end

endmodule

`default_nettype wire

/* src/nbf_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module nbf_loader
   (
      input  wire                      clk_i,
      input  wire                      rst_i,
      input  wire                      cfg_done_i,
      input  wire                      nbf_v_i,
      input  wire boot_pkg::nbf_op_e   nbf_op_i,
      input  wire [`BOOT_ADDR_W-1:0]   nbf_addr_i,
      input  wire [`BOOT_DATA_W-1:0]   nbf_data_i,
      output logic                     nbf_ready_o,
      output logic                     io_cmd_v_o,
      output logic [`BOOT_ADDR_W-1:0]  io_cmd_addr_o,
      output logic [`BOOT_DATA_W-1:0]  io_cmd_data_o,
      input  wire                      io_cmd_yumi_i,
      input  wire                      io_resp_v_i,
      output logic                     io_resp_ready_o,
      output logic                     done_o
   );

   boot_pkg::loader_state_e      state_q;
   boot_pkg::nbf_op_e            op_q;
   logic [`BOOT_ADDR_W-1:0]      addr_q;
   logic [`BOOT_DATA_W-1:0]      data_q;
   logic                         accept;

   assign nbf_ready_o = cfg_done_i && (state_q == boot_pkg::ld_idle);
   assign accept      = nbf_v_i && nbf_ready_o;

   // Finish turns into a write clearing freeze
   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         op_q <= nbf_op_i;
         if (nbf_op_i == boot_pkg::nbf_op_finish)
         begin
            addr_q <= `BOOT_FREEZE_ADDR;
            data_q <= '0;
         end
         else
         begin
            addr_q <= nbf_addr_i;
            data_q <= nbf_data_i;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_q <= boot_pkg::ld_idle;
      else
      begin
         case (state_q)
            boot_pkg::ld_idle:
               if (accept)
                  state_q <= boot_pkg::ld_cmd;
            boot_pkg::ld_cmd:
               if (io_cmd_yumi_i)
                  state_q <= boot_pkg::ld_resp;
            boot_pkg::ld_resp:
               if (io_resp_v_i)
                  state_q <= (op_q == boot_pkg::nbf_op_finish) ? boot_pkg::ld_done
                                                                : boot_pkg::ld_idle;
            default:
               state_q <= boot_pkg::ld_done;
         endcase
      end
   end

   assign io_cmd_v_o      = (state_q == boot_pkg::ld_cmd);
   assign io_cmd_addr_o   = addr_q;
   assign io_cmd_data_o   = data_q;
   assign io_resp_ready_o = (state_q == boot_pkg::ld_resp);
   assign done_o          = (state_q == boot_pkg::ld_done);

   // Done is sticky and the stream stays closed
   a_done_closed: assert property (@(posedge clk_i) disable iff (rst_i)
      done_o |=> (done_o && !nbf_ready_o))
      else $error("nbf_loader: stream reopened after done");

endmodule

`default_nettype wire

/* tb/tb_boot.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_cfg.svh"

module tb_boot;

   localparam int n_writes_lp = 60;
   localparam int n_extra_lp  = 5;
   localparam int n_addr_lp   = 32;
   localparam int hold_lp     = 8;
   // 2000 records at 2 cycles each
   localparam int timeout_lp  = 2000 * 2;

   logic                         clk;
   logic                         rst;
   logic                         nbf_v;
   boot_pkg::nbf_op_e            nbf_op;
   logic [`BOOT_ADDR_W-1:0]      nbf_addr;
   logic [`BOOT_DATA_W-1:0]      nbf_data;
   logic                         nbf_ready;
   logic [`BOOT_ADDR_W-1:0]      host_rd_addr;
   logic [`BOOT_DATA_W-1:0]      host_rd_data;
   logic                         freeze;
   logic                         done;

   logic [15:0]                  lfsr_q;
   logic [`BOOT_DATA_W-1:0]      model_mem [n_addr_lp];
   logic                         written [n_addr_lp];
   int                           accepted_writes;
   int                           cycle_cnt;

   boot_top i_dut
      (.clk_i(clk)
      ,.rst_i(rst)
      ,.nbf_v_i(nbf_v)
      ,.nbf_op_i(nbf_op)
      ,.nbf_addr_i(nbf_addr)
      ,.nbf_data_i(nbf_data)
      ,.nbf_ready_o(nbf_ready)
      ,.host_rd_addr_i(host_rd_addr)
      ,.host_rd_data_o(host_rd_data)
      ,.freeze_o(freeze)
      ,.done_o(done)
      );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // 16-bit Galois LFSR with taps 16 14 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic lsb;
      lsb = s[0];
      lfsr_next = s >> 1;
      if (lsb)
         lfsr_next = lfsr_next ^ 16'hB400;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
         stop_run($sformatf("Mismatch at %0t ns: %s (got 0x%08h, expected 0x%08h)",
                            $time, what, actual, expected));
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Read data is registered, so it shows up one edge after the address
   task automatic host_read(input logic [`BOOT_ADDR_W-1:0] addr,
                            output logic [`BOOT_DATA_W-1:0] data);
      host_rd_addr = addr;
      next_cycle();
      data = host_rd_data;
   endtask

   task automatic check_table();
      logic [`BOOT_DATA_W-1:0] rd;
      for (int i = 0; i < `BOOT_TABLE_WORDS; i++)
      begin
         host_read(`BOOT_TABLE_BASE + i, rd);
         check_equal(rd, 32'(i) ^ `BOOT_TABLE_KEY, $sformatf("table entry %0d", i));
      end
   endtask

   task automatic check_ram();
      logic [`BOOT_DATA_W-1:0] rd;
      for (int a = 0; a < n_addr_lp; a++)
      begin
         if (written[a])
         begin
            host_read(`BOOT_ADDR_W'(a), rd);
            check_equal(rd, model_mem[a], $sformatf("RAM word %0d", a));
         end
      end
   endtask

   // Random idle gap, then hold the record until a cycle with ready high
   task automatic offer_record(input boot_pkg::nbf_op_e op,
                               input logic [`BOOT_ADDR_W-1:0] addr,
                               input logic [`BOOT_DATA_W-1:0] data);
      logic [31:0] gap;
      logic        taken;
      take_bits(2, gap);
      repeat (gap) next_cycle();
      nbf_v    = 1'b1;
      nbf_op   = op;
      nbf_addr = addr;
      nbf_data = data;
      taken    = 1'b0;
      while (!taken)
      begin
         // Ready only changes on a clock edge
         taken = nbf_ready;
         next_cycle();
      end
      nbf_v = 1'b0;
   endtask

   // Write handshakes as the DUT sees them at its stream port
   always @(negedge clk)
   begin
      if (!rst && nbf_v && nbf_ready && (nbf_op == boot_pkg::nbf_op_write))
         accepted_writes++;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_lp)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      stop_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_lp));
   end

   initial
   begin
      logic [31:0] rd;
      logic [31:0] a;
      logic [31:0] d;
      rst             = 1'b1;
      nbf_v           = 1'b0;
      nbf_op          = boot_pkg::nbf_op_write;
      nbf_addr        = '0;
      nbf_data        = '0;
      host_rd_addr    = '0;
      lfsr_q          = 16'd2281;
      accepted_writes = 0;
      for (int i = 0; i < n_addr_lp; i++)
      begin
         model_mem[i] = '0;
         written[i]   = 1'b0;
      end

      repeat (5) @(posedge clk);
      #1 rst = 1'b0;

      // Freeze write and table fill take 2 cycles per write
      for (int i = 0; i < 2 * (`BOOT_TABLE_WORDS + 1); i++)
      begin
         check_equal(32'(nbf_ready), 32'd0, "nbf_ready_o before table complete");
         next_cycle();
      end
      while (!nbf_ready)
         next_cycle();
      check_equal(32'(freeze), 32'd1, "freeze_o when stream opens");
      host_read(`BOOT_FREEZE_ADDR, rd);
      check_equal(rd, 32'd1, "freeze register via host port");
      check_table();

      for (int w = 0; w < n_writes_lp; w++)
      begin
         take_bits(5, a);
         take_bits(32, d);
         offer_record(boot_pkg::nbf_op_write, {7'd0, a[4:0]}, d);
         model_mem[a[4:0]] = d;
         written[a[4:0]]   = 1'b1;
      end
      check_equal(32'(accepted_writes), 32'(n_writes_lp), "accepted write count");

      offer_record(boot_pkg::nbf_op_finish, '0, '0);
      while (!done)
         next_cycle();
      check_equal(32'(freeze), 32'd0, "freeze_o after finish");
      host_read(`BOOT_FREEZE_ADDR, rd);
      check_equal(rd, 32'd0, "freeze register after finish");
      check_table();
      check_ram();

      // Records after done must be refused
      for (int e = 0; e < n_extra_lp; e++)
      begin
         take_bits(5, a);
         take_bits(32, d);
         nbf_v    = 1'b1;
         nbf_op   = boot_pkg::nbf_op_write;
         nbf_addr = {7'd0, a[4:0]};
         nbf_data = d;
         repeat (hold_lp)
         begin
            check_equal(32'(nbf_ready), 32'd0, "nbf_ready_o after done");
            next_cycle();
         end
         nbf_v = 1'b0;
         check_equal(32'(done), 32'd1, "done_o stays high");
      end
      check_ram();

      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/boot_pkg.sv
src/cfg_loader.sv
src/nbf_loader.sv
src/load_arbiter.sv
src/io_target.sv
src/boot_top.sv
tb/tb_boot.sv
